//--- hdl/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int K_WIDTH     = 3;   // taps along the row
    localparam int MAX_NIF     = 4;   // input channels per position
    localparam int MAX_IX      = 32;  // widest row in pixels
    localparam int LANES       = 8;   // result lanes
    localparam int ACC_W       = 16;  // lane sum width
    localparam int IN_DEPTH    = 4;   // input fifo entries
    localparam int OUT_DEPTH   = 4;   // output fifo entries
    localparam int OUT_CREDITS = 2;   // credits held after reset

    // derived
    localparam int N_TAPS    = K_WIDTH * MAX_NIF;       // pixels in one window
    localparam int CH_W      = $clog2(MAX_NIF);         // channel counter
    localparam int POS_W     = $clog2(MAX_IX);          // position counter
    localparam int IN_PTR_W  = $clog2(IN_DEPTH);
    localparam int OUT_PTR_W = $clog2(OUT_DEPTH);
    localparam int CRED_W    = $clog2(OUT_CREDITS + 1);

    // pop to pe result latency
    // one cycle window register plus two pe stages
    localparam int PIPE_LAT = 3;
    localparam int RSV_W    = $clog2(OUT_DEPTH + PIPE_LAT + 1);  // fifo plus in flight

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic signed [7:0]       pixel_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef struct packed {
        logic       mode;  // 0 = 8b weights, 1 = binary weights
        logic [2:0] nif;   // 1..4
        logic [5:0] ix;    // 4..32
    } cfg_t;

    // one weight byte, two readings
    typedef union packed {
        logic signed [7:0] w8;  // mode 0
        logic [7:0]        w1;  // mode 1, bit n drives lane n
    } weight_u;

    typedef struct packed {
        logic       valid;
        logic [3:0] addr;  // position * MAX_NIF + channel
        weight_u    data;
    } weight_load_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pixel_beat_t;

    // pix index = position * MAX_NIF + channel, position 0 is the oldest
    typedef struct packed {
        logic                valid;
        pixel_t [N_TAPS-1:0] pix;
    } window_t;

    typedef struct packed {
        logic              valid;
        logic              mode;
        acc_t [LANES-1:0]  lane;  // mode 0 uses lane 0 only
    } result_t;

endpackage

//--- hdl/conv_in_fifo.sv
`timescale 1ns/1ps

module conv_in_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::pixel_beat_t pixel_in,
    input  logic                  reserve_ok,
    output conv_pkg::pixel_beat_t pixel_out,
    output logic                  in_credit
);

    conv_pkg::pixel_t mem [conv_pkg::IN_DEPTH];  // pixel storage

    logic [conv_pkg::IN_PTR_W-1:0] wr_ptr;
    logic [conv_pkg::IN_PTR_W-1:0] rd_ptr;
    logic [conv_pkg::IN_PTR_W:0]   count;    // entries held
    logic                          pop;

    // pop only when the out stage has a slot for it
    assign pop = (count != '0) && reserve_ok;

    assign in_credit       = pop;  // one credit back per pop
    assign pixel_out.valid = pop;
    assign pixel_out.data  = mem[rd_ptr];  // head, read through

    // storage, no reset
    always_ff @(posedge clk) begin
        if (pixel_in.valid) begin
            mem[wr_ptr] <= pixel_in.data;
        end
    end

    ////////////////////////////////////////
    // pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pixel_in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({pixel_in.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

endmodule

//--- hdl/conv_window_buffer.sv
`timescale 1ns/1ps

module conv_window_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::cfg_t        cfg,
    input  conv_pkg::pixel_beat_t pixel_in,
    output conv_pkg::window_t     window
);

    conv_pkg::pixel_t [conv_pkg::MAX_NIF-1:0] cur;        // position being filled
    conv_pkg::pixel_t [conv_pkg::MAX_NIF-1:0] new_pos;    // cur plus this beat
    conv_pkg::pixel_t [conv_pkg::N_TAPS-1:0]  taps;       // last three positions
    conv_pkg::pixel_t [conv_pkg::N_TAPS-1:0]  taps_next;
    conv_pkg::pixel_t [conv_pkg::N_TAPS-1:0]  win_pix;    // window payload

    logic [conv_pkg::CH_W-1:0]  ch_cnt;   // channel within position
    logic [conv_pkg::POS_W-1:0] pos_cnt;  // position within row
    logic [2:0]                 last_ch;
    logic [5:0]                 last_pos;
    logic                       pos_done;
    logic                       row_end;
    logic                       win_valid;

    assign last_ch  = cfg.nif - 3'd1;
    assign last_pos = cfg.ix - 6'd1;

    // beat that closes a position
    assign pos_done = pixel_in.valid && (ch_cnt == last_ch[conv_pkg::CH_W-1:0]);
    // last position of the row
    assign row_end  = pos_done && (pos_cnt == last_pos[conv_pkg::POS_W-1:0]);

    ////////////////////////////////////////
    // shift in the completed position
    ////////////////////////////////////////

    always_comb begin
        new_pos         = cur;
        new_pos[ch_cnt] = pixel_in.data;
        // newest position enters at the top, oldest drops out at 0
        taps_next = {new_pos, taps[conv_pkg::N_TAPS-1:conv_pkg::MAX_NIF]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ch_cnt    <= '0;
            pos_cnt   <= '0;
            cur       <= '0;
            taps      <= '0;
            win_valid <= 1'b0;
        end else begin
            // third position onward gives a window
            win_valid <= pos_done && (pos_cnt >= conv_pkg::POS_W'(conv_pkg::K_WIDTH - 1));
            if (pos_done) begin
                ch_cnt  <= '0;
                cur     <= '0;  // unused channels stay zero
                taps    <= row_end ? '0 : taps_next;        // clear at row end
                pos_cnt <= row_end ? '0 : pos_cnt + 1'b1;
            end else if (pixel_in.valid) begin
                cur[ch_cnt] <= pixel_in.data;
                ch_cnt      <= ch_cnt + 1'b1;
            end
        end
    end

    // payload captured apart from taps, so a row end still emits its last window
    always_ff @(posedge clk) begin
        if (pos_done) begin
            win_pix <= taps_next;
        end
    end

    assign window.valid = win_valid;
    assign window.pix   = win_pix;

endmodule

//--- hdl/conv_pe_array.sv
`timescale 1ns/1ps

module conv_pe_array (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_pkg::cfg_t         cfg,
    input  conv_pkg::weight_load_t weight_load,
    input  conv_pkg::window_t      window,
    output conv_pkg::result_t      result
);

    conv_pkg::weight_u w_reg [conv_pkg::N_TAPS];  // one per tap

    conv_pkg::acc_t term_d [conv_pkg::LANES][conv_pkg::N_TAPS];
    conv_pkg::acc_t term_q [conv_pkg::LANES][conv_pkg::N_TAPS];  // stage 1

    conv_pkg::acc_t [conv_pkg::LANES-1:0] sum_d;
    conv_pkg::acc_t [conv_pkg::LANES-1:0] res_lane;  // stage 2

    logic s1_valid;
    logic s1_mode;
    logic res_valid;
    logic res_mode;

    // one term of one lane
    function automatic conv_pkg::acc_t tap_term(
        input logic              mode,
        input int                lane,
        input conv_pkg::pixel_t  pix,
        input conv_pkg::weight_u w
    );
        conv_pkg::acc_t p;
        p = conv_pkg::acc_t'(pix);  // sign extend
        if (mode) begin
            return w.w1[lane] ? p : -p;  // bit 1 adds, bit 0 subtracts
        end
        if (lane == 0) begin
            return p * conv_pkg::acc_t'(w.w8);
        end
        return '0;  // lanes 1..7 idle in 8b mode
    endfunction

    ////////////////////////////////////////
    // weight registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (weight_load.valid && (weight_load.addr < conv_pkg::N_TAPS)) begin
            w_reg[weight_load.addr] <= weight_load.data;
        end
    end

    // stage 1 products
    always_comb begin
        for (int l = 0; l < conv_pkg::LANES; l++) begin
            for (int t = 0; t < conv_pkg::N_TAPS; t++) begin
                term_d[l][t] = tap_term(cfg.mode, l, window.pix[t], w_reg[t]);
            end
        end
    end

    // stage 2 sums, wrap at ACC_W
    always_comb begin
        for (int l = 0; l < conv_pkg::LANES; l++) begin
            sum_d[l] = '0;
            for (int t = 0; t < conv_pkg::N_TAPS; t++) begin
                sum_d[l] = sum_d[l] + term_q[l][t];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= window.valid;
            res_valid <= s1_valid;
        end
    end

    // payload stages
    always_ff @(posedge clk) begin
        term_q   <= term_d;
        s1_mode  <= cfg.mode;
        res_mode <= s1_mode;
        res_lane <= sum_d;
    end

    assign result.valid = res_valid;
    assign result.mode  = res_mode;
    assign result.lane  = res_lane;

endmodule

//--- hdl/conv_out_stage.sv
`timescale 1ns/1ps

module conv_out_stage (
    input  logic              clk,
    input  logic              rst,
    input  conv_pkg::result_t result_in,
    input  logic              out_credit,
    input  logic              pop,
    output conv_pkg::result_t result_out,
    output logic              reserve_ok
);

    conv_pkg::result_t mem [conv_pkg::OUT_DEPTH];  // result storage

    logic [conv_pkg::OUT_PTR_W-1:0] wr_ptr;
    logic [conv_pkg::OUT_PTR_W-1:0] rd_ptr;
    logic [conv_pkg::OUT_PTR_W:0]   count;     // results held
    logic [conv_pkg::CRED_W-1:0]    credits;   // sink credits held
    logic [conv_pkg::PIPE_LAT-1:0]  pop_sr;    // one slot per pop in flight
    logic [conv_pkg::RSV_W-1:0]     reserved;  // held plus reserved
    logic                           send;

    ////////////////////////////////////////
    // slot reservation
    ////////////////////////////////////////

    // every pop may close a position, so each holds a slot until its
    // result would have arrived
    always_comb begin
        reserved = (conv_pkg::RSV_W)'(count);
        for (int i = 0; i < conv_pkg::PIPE_LAT; i++) begin
            reserved = reserved + (conv_pkg::RSV_W)'(pop_sr[i]);
        end
        reserve_ok = reserved < conv_pkg::OUT_DEPTH;  // room for one more
    end

    assign send = (count != '0) && (credits != '0);

    always_comb begin
        result_out       = mem[rd_ptr];
        result_out.valid = send;
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (result_in.valid) begin
            mem[wr_ptr] <= result_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= (conv_pkg::CRED_W)'(conv_pkg::OUT_CREDITS);
            pop_sr  <= '0;
        end else begin
            pop_sr <= {pop_sr[conv_pkg::PIPE_LAT-2:0], pop};  // slot released at the end
            if (result_in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({result_in.valid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;  // sink returned one
                2'b01:   credits <= credits - 1'b1;  // spent on a send
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- hdl/conv_datapath_front.sv
`timescale 1ns/1ps

module conv_datapath_front (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_pkg::cfg_t         cfg,
    input  conv_pkg::weight_load_t weight_load,
    input  conv_pkg::pixel_beat_t  pixel_in,
    input  logic                   out_credit,
    output logic                   in_credit,
    output conv_pkg::result_t      result_out
);

    conv_pkg::pixel_beat_t fifo_pixel;  // popped pixel
    conv_pkg::window_t     window;
    conv_pkg::result_t     pe_result;
    logic                  reserve_ok;  // out stage has a free slot

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    conv_in_fifo conv_in_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .pixel_in   (pixel_in),
        .reserve_ok (reserve_ok),
        .pixel_out  (fifo_pixel),
        .in_credit  (in_credit)
    );

    conv_window_buffer conv_window_buffer_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .pixel_in (fifo_pixel),
        .window   (window)
    );

    ////////////////////////////////////////
    // compute and output side
    ////////////////////////////////////////

    conv_pe_array conv_pe_array_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .weight_load (weight_load),
        .window      (window),
        .result      (pe_result)
    );

    // in_credit marks each pop
    conv_out_stage conv_out_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .result_in  (pe_result),
        .out_credit (out_credit),
        .pop        (in_credit),
        .result_out (result_out),
        .reserve_ok (reserve_ok)
    );

endmodule

//--- tb/conv_datapath_front_props.sv
`timescale 1ns/1ps

module conv_datapath_front_props (
    input logic                  clk,
    input logic                  rst,
    input conv_pkg::pixel_beat_t pixel_in,
    input logic                  out_credit,
    input logic                  in_credit,
    input conv_pkg::result_t     result_out
);

    int fill;  // input fifo level seen from outside
    int cred;  // output credits held by the DUT

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= 0;
            cred <= conv_pkg::OUT_CREDITS;
        end else begin
            fill <= fill + int'(pixel_in.valid) - int'(in_credit);
            cred <= cred + int'(out_credit) - int'(result_out.valid);
        end
    end

    // no beat into a full fifo unless one leaves
    no_in_overflow: assert property (@(posedge clk) disable iff (rst)
        fill + int'(pixel_in.valid) <= conv_pkg::IN_DEPTH + int'(in_credit))
        else $error("input fifo overflow");

    no_send_without_credit: assert property (@(posedge clk) disable iff (rst)
        result_out.valid |-> cred > 0)
        else $error("result sent with zero credits");

    quiet_after_reset: assert property (@(posedge clk)
        ($past(rst) && !rst) |-> (!in_credit && !result_out.valid))
        else $error("activity in the cycle after reset");

endmodule

bind conv_datapath_front conv_datapath_front_props conv_datapath_front_props_inst (.*);

//--- tb/conv_datapath_front_tb.sv
`timescale 1ns/1ps

module conv_datapath_front_tb;

    localparam int TMO = 2000;  // cycles per wait

    logic                   clk = 1'b0;
    logic                   rst;
    conv_pkg::cfg_t         cfg;
    conv_pkg::weight_load_t weight_load;
    conv_pkg::pixel_beat_t  pixel_in;
    logic                   out_credit = 1'b0;
    logic                   in_credit;
    conv_pkg::result_t      result_out;

    logic [8*conv_pkg::ACC_W-1:0] exp_q [$];  // expected lanes, lane 0 lowest
    logic                         exp_mode_q [$];

    int          credit_cnt   = 0;  // in_credit pulses seen
    int          sent_cnt     = 0;  // pixels driven
    int          owed_cnt     = 0;  // results taken, credit owed
    int          returned_cnt = 0;
    int          gap          = 0;
    int          mismatch_cnt = 0;
    int          other_cnt    = 0;
    logic [31:0] rng          = 32'd95044;

    conv_datapath_front conv_datapath_front_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .weight_load (weight_load),
        .pixel_in    (pixel_in),
        .out_credit  (out_credit),
        .in_credit   (in_credit),
        .result_out  (result_out)
    );

    always #4 clk = ~clk;  // 8 ns

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s at %0t", msg, $time);
        other_cnt++;
        $display("errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt);
        $display("sim failed");
        $finish;
    endtask

    task automatic check_result();
        logic [8*conv_pkg::ACC_W-1:0] e;
        assert (exp_q.size() > 0) else begin
            $display("unexpected result at %0t with no expected record left", $time);
            other_cnt++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (result_out.mode == exp_mode_q[0]) else begin
                $display("Mismatch at %0t: result_out.mode got %0d expected %0d",
                         $time, result_out.mode, exp_mode_q[0]);
                mismatch_cnt++;
            end
            for (int l = 0; l < conv_pkg::LANES; l++) begin
                if (exp_mode_q[0] || l == 0) begin  // 8b mode: lane 0 only
                    assert (result_out.lane[l] == e[l*conv_pkg::ACC_W +: conv_pkg::ACC_W])
                    else begin
                        $display("Mismatch at %0t: result_out.lane[%0d] got %0d expected %0d",
                                 $time, l, result_out.lane[l],
                                 $signed(e[l*conv_pkg::ACC_W +: conv_pkg::ACC_W]));
                        mismatch_cnt++;
                    end
                end
            end
            void'(exp_mode_q.pop_front());
        end
        // a window needs three full positions
        assert (sent_cnt >= 3 * int'(cfg.nif)) else begin
            $display("result at %0t before three positions were sent", $time);
            other_cnt++;
        end
        owed_cnt++;
    endtask

    // sampled at negedge, between drive points
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) credit_cnt++;
            if (result_out.valid) check_result();
        end
    end

    ////////////////////////////////////////
    // sink, credit return
    ////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        out_credit = 1'b0;
        if (rst) begin
            gap = 0;
        end else if (gap > 0) begin
            gap = gap - 1;
        end else if (owed_cnt > returned_cnt) begin
            out_credit = 1'b1;
            returned_cnt++;
            rng = xorshift32(rng);
            gap = (returned_cnt == 3) ? 40 : int'(rng % 4);  // one long hold
        end
    end

    task automatic send_pixel(input int v);
        int t;
        t = 0;
        // third position held one beat short for a while, no result may show meanwhile
        if (sent_cnt == 3 * int'(cfg.nif) - 1) begin
            pixel_in.valid = 1'b0;
            repeat (8) begin
                @(posedge clk);
                #1;
            end
        end
        while (conv_pkg::IN_DEPTH + credit_cnt - sent_cnt <= 0) begin
            pixel_in.valid = 1'b0;
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) stop_on_error("timeout waiting for an input credit");
        end
        pixel_in.valid = 1'b1;
        pixel_in.data  = 8'(v);
        sent_cnt++;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int t;
        t = 0;
        pixel_in.valid = 1'b0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) stop_on_error("timeout waiting for expected results");
        end
    endtask

    task automatic load_weight(input int addr, input logic [7:0] b);
        weight_load.valid   = 1'b1;
        weight_load.addr    = 4'(addr);
        weight_load.data.w1 = b;
        @(posedge clk);
        #1;
        weight_load.valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // file driven stimulus
    ////////////////////////////////////////

    initial begin
        int                           fd;
        int                           code;
        int                           a;
        int                           b;
        int                           c;
        byte                          tag;
        string                        line;
        logic [8*conv_pkg::ACC_W-1:0] e;
        rst         = 1'b1;
        cfg         = '0;
        weight_load = '0;
        pixel_in    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = $fopen("tb/conv_tests.txt", "r");
        if (fd == 0) stop_on_error("cannot open tb/conv_tests.txt");
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": code = $fgets(line, fd);  // comment line
                "C": begin
                    code = $fscanf(fd, "%d %d %d", a, b, c);
                    if (code != 3) stop_on_error("malformed C record in tb/conv_tests.txt");
                    drain();
                    cfg.mode = a[0];
                    cfg.nif  = 3'(b);
                    cfg.ix   = 6'(c);
                end
                "W": begin
                    code = $fscanf(fd, "%d %h", a, b);
                    if (code != 2) stop_on_error("malformed W record in tb/conv_tests.txt");
                    drain();
                    load_weight(a, 8'(b));
                end
                "P": begin
                    code = $fscanf(fd, "%d", a);
                    if (code != 1) stop_on_error("malformed P record in tb/conv_tests.txt");
                    send_pixel(a);
                end
                "E": begin
                    for (int l = 0; l < conv_pkg::LANES; l++) begin
                        code = $fscanf(fd, "%d", a);
                        if (code != 1) begin
                            stop_on_error("malformed E record in tb/conv_tests.txt");
                        end
                        e[l*conv_pkg::ACC_W +: conv_pkg::ACC_W] = conv_pkg::ACC_W'(a);
                    end
                    exp_q.push_back(e);
                    exp_mode_q.push_back(cfg.mode);
                end
                default: stop_on_error("unknown record in tb/conv_tests.txt");
            endcase
        end
        $fclose(fd);
        drain();
        repeat (4) @(posedge clk);  // catch any stray result
        $display("errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb/conv_tests.txt
# C mode nif ix | W addr byte_hex | P pixel | E lane0 .. lane7 (decimal)
# records run in order, E records queue the results of the pixels that follow
C 0 1 8
W 0 01 W 1 00 W 2 00 W 3 00
W 4 02 W 5 00 W 6 00 W 7 00
W 8 ff W 9 00 W 10 00 W 11 00
E 2 0 0 0 0 0 0 0
E 4 0 0 0 0 0 0 0
E 6 0 0 0 0 0 0 0
E 8 0 0 0 0 0 0 0
E 10 0 0 0 0 0 0 0
E 12 0 0 0 0 0 0 0
E -20 0 0 0 0 0 0 0
E 20 0 0 0 0 0 0 0
E -20 0 0 0 0 0 0 0
E 20 0 0 0 0 0 0 0
E -20 0 0 0 0 0 0 0
E 20 0 0 0 0 0 0 0
P 1 P 2 P 3 P 4 P 5 P 6 P 7 P 8
P 10 P -10 P 10 P -10 P 10 P -10 P 10 P -10
C 1 4 4
W 0 0f W 1 0f W 2 0f W 3 0f
W 4 33 W 5 33 W 6 33 W 7 33
W 8 55 W 9 55 W 10 55 W 11 55
E 11 1 19 9 -9 -19 -1 -11
E 9 -7 -1 -17 17 1 7 -9
P 1 P 2 P 3 P 4 P -1 P -1 P -1 P -1 P 5 P 0 P 0 P 0 P 2 P 2 P 2 P 2
C 0 1 4
W 0 03 W 4 00 W 8 01
E 6 0 0 0 0 0 0 0
E 10 0 0 0 0 0 0 0
P 1 P 2 P 3 P 4

//--- compile.f
hdl/conv_pkg.sv
hdl/conv_in_fifo.sv
hdl/conv_window_buffer.sv
hdl/conv_pe_array.sv
hdl/conv_out_stage.sv
hdl/conv_datapath_front.sv
tb/conv_datapath_front_props.sv
tb/conv_datapath_front_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f compile.f \
		--top-module conv_datapath_front_tb -o conv_sim
	./obj_dir/conv_sim | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
